// File: verilog/cpu_mem_pkg.sv
package cpu_mem_pkg;

	// Address map
	localparam logic [31:0] RESET_PC      = 32'h3000_0000;
	localparam logic [31:0] CLINT_BASE    = 32'h0200_0000;
	localparam logic [31:0] CLINT_MASK    = 32'hffff_0000;
	localparam logic [15:0] MTIME_LO_ADDR = 16'hbff8;
	localparam logic [15:0] MTIME_HI_ADDR = 16'hbffc;

	// Instruction cache geometry with one refill burst per line
	localparam int LINE_WORDS   = 4;
	localparam int ICACHE_LINES = 16;
	localparam int OFFSET_W     = $clog2(LINE_WORDS);
	localparam int INDEX_W      = $clog2(ICACHE_LINES);
	localparam int TAG_W        = 32 - INDEX_W - OFFSET_W - 2;

	// AXI constants seen on the master port
	localparam logic [3:0] AXI_ID_IFU     = 4'd0;
	localparam logic [3:0] AXI_ID_LSU     = 4'd1;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;
	localparam logic [1:0] AXI_RESP_SLV   = 2'b10;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
		logic [3:0]  id;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
		logic [3:0] id;
	} axi_b_t;

	// Load/store side request and response
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic [2:0]  size;
		logic        write;
	} lsu_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic [1:0]  resp;
	} lsu_rsp_t;

endpackage

// File: verilog/icache.sv
`timescale 1ns/1ns

module icache (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        fence_i,
	input  logic [31:0] lookup_addr,
	output logic        hit,
	output logic [31:0] hit_data,
	input  logic        fill_en,
	input  logic [31:0] fill_addr,
	input  logic [31:0] fill_data,
	input  logic        fill_done
);

	import cpu_mem_pkg::*;

	logic [31:0]        data_mem [ICACHE_LINES][LINE_WORDS];
	logic [TAG_W-1:0]   tag_mem  [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] valid_q;

	logic [INDEX_W-1:0]  lk_index;
	logic [OFFSET_W-1:0] lk_offset;
	logic [TAG_W-1:0]    lk_tag;
	logic [INDEX_W-1:0]  fl_index;
	logic [OFFSET_W-1:0] fl_offset;
	logic [TAG_W-1:0]    fl_tag;

	// Address split into tag, index, word offset and byte offset
	assign lk_offset = lookup_addr[2 +: OFFSET_W];
	assign lk_index  = lookup_addr[2 + OFFSET_W +: INDEX_W];
	assign lk_tag    = lookup_addr[31 -: TAG_W];

	assign fl_offset = fill_addr[2 +: OFFSET_W];
	assign fl_index  = fill_addr[2 + OFFSET_W +: INDEX_W];
	assign fl_tag    = fill_addr[31 -: TAG_W];

	// Lookup is purely combinational
	assign hit      = valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
	assign hit_data = data_mem[lk_index][lk_offset];

	always_ff @(posedge clock) begin
		if (fill_en) begin
			data_mem[fl_index][fl_offset] <= fill_data;
		end
		if (fill_done) begin
			tag_mem[fl_index] <= fl_tag;
		end
	end

	// A line becomes valid only after its last refill word is written
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (fence_i) begin
			valid_q <= '0;
		end else if (fill_done) begin
			valid_q[fl_index] <= 1'b1;
		end
	end

	// The fetch unit drops refill writes in the cycle of a fence.i pulse
	a_no_fill_on_fence: assert property (
		@(posedge clock) disable iff (!arst_n)
		!(fill_en && fence_i)
	);

endmodule

// File: verilog/ifu.sv
`timescale 1ns/1ns

module ifu (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 redirect,
	input  logic [31:0]          redirect_pc,
	input  logic                 fence_i,
	output logic [31:0]          inst,
	output logic [31:0]          inst_pc,
	output logic                 inst_valid,
	input  logic                 inst_ready,
	output cpu_mem_pkg::axi_ar_t ar,
	output logic                 arvalid,
	input  logic                 arready,
	input  cpu_mem_pkg::axi_r_t  r,
	input  logic                 rvalid,
	output logic                 rready,
	output logic [31:0]          lookup_addr,
	input  logic                 hit,
	input  logic [31:0]          hit_data,
	output logic                 fill_en,
	output logic [31:0]          fill_addr,
	output logic [31:0]          fill_data,
	output logic                 fill_done
);

	import cpu_mem_pkg::*;

	typedef enum logic [1:0] {
		S_LOOKUP,
		S_REQUEST,
		S_REFILL,
		S_PRESENT
	} state_t;

	state_t              state_q;
	logic [31:0]         pc_q;
	logic [31:0]         inst_q;
	logic [OFFSET_W-1:0] beat_q;
	logic                redir_pend_q;
	logic [31:0]         redir_pc_q;
	logic                fence_seen_q;
	logic                rd_beat;
	logic                refill_end;

	assign rd_beat    = rvalid && rready;
	assign refill_end = rd_beat && r.last;

	assign lookup_addr = pc_q;
	assign inst        = inst_q;
	assign inst_pc     = pc_q;
	assign inst_valid  = (state_q == S_PRESENT);

	// Line-aligned INCR burst for the current PC
	assign arvalid  = (state_q == S_REQUEST);
	assign ar.addr  = {pc_q[31:OFFSET_W+2], {(OFFSET_W + 2){1'b0}}};
	assign ar.id    = AXI_ID_IFU;
	assign ar.len   = 8'(LINE_WORDS - 1);
	assign ar.size  = 3'd2;
	assign ar.burst = AXI_BURST_INCR;
	assign rready   = (state_q == S_REFILL);

	// Refill words go straight into the cache
	// A fence mid-refill keeps the line invalid
	assign fill_en   = rd_beat && !fence_i;
	assign fill_addr = {pc_q[31:OFFSET_W+2], beat_q, 2'b00};
	assign fill_data = r.data;
	assign fill_done = refill_end && !fence_i && !fence_seen_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q      <= S_LOOKUP;
			pc_q         <= RESET_PC;
			beat_q       <= '0;
			redir_pend_q <= 1'b0;
			fence_seen_q <= 1'b0;
		end else begin
			fence_seen_q <= fence_i || (fence_seen_q && state_q != S_LOOKUP);
			if (rd_beat) begin
				beat_q <= beat_q + 1'b1;
			end
			// A redirect during a burst waits for the burst to finish
			if (redirect && (state_q == S_REQUEST || (state_q == S_REFILL && !refill_end))) begin
				redir_pend_q <= 1'b1;
			end
			case (state_q)
				S_LOOKUP: begin
					if (redirect) begin
						pc_q <= redirect_pc;
					end else if (hit) begin
						state_q <= S_PRESENT;
					end else begin
						state_q <= S_REQUEST;
					end
				end
				S_REQUEST: begin
					if (arready) begin
						state_q <= S_REFILL;
						beat_q  <= '0;
					end
				end
				S_REFILL: begin
					if (refill_end && (redirect || redir_pend_q)) begin
						pc_q         <= redirect ? redirect_pc : redir_pc_q;
						redir_pend_q <= 1'b0;
						state_q      <= S_LOOKUP;
					end else if (refill_end) begin
						state_q <= S_PRESENT;
					end
				end
				default: begin
					if (redirect) begin
						pc_q    <= redirect_pc;
						state_q <= S_LOOKUP;
					end else if (inst_ready) begin
						pc_q    <= pc_q + 32'd4;
						state_q <= S_LOOKUP;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == S_LOOKUP && hit) begin
			inst_q <= hit_data;
		end
		// Keep the beat that carries the word at the current PC
		if (rd_beat && beat_q == pc_q[2 +: OFFSET_W]) begin
			inst_q <= r.data;
		end
		if (redirect && (state_q == S_REQUEST || state_q == S_REFILL)) begin
			redir_pc_q <= redirect_pc;
		end
	end

	a_ar_stable: assert property (
		@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(ar)
	);

	// Burst has LINE_WORDS beats and last sits on the final one
	a_refill_len: assert property (
		@(posedge clock) disable iff (!arst_n)
		rd_beat |-> (r.last == (beat_q == OFFSET_W'(LINE_WORDS - 1)))
	);

endmodule

// File: verilog/clint.sv
`timescale 1ns/1ns

module clint (
	input  logic                 clock,
	input  logic                 arst_n,
	input  cpu_mem_pkg::axi_ar_t ar,
	input  logic                 arvalid,
	output logic                 arready,
	output cpu_mem_pkg::axi_r_t  r,
	output logic                 rvalid,
	input  logic                 rready
);

	import cpu_mem_pkg::*;

	logic [63:0] mtime_q;
	logic        rvalid_q;
	axi_r_t      r_q;
	logic [15:0] offset;

	assign offset  = ar.addr[15:0];
	assign arready = !rvalid_q;
	assign rvalid  = rvalid_q;
	assign r       = r_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mtime_q  <= '0;
			rvalid_q <= 1'b0;
		end else begin
			mtime_q <= mtime_q + 64'd1;
			if (arvalid && arready) begin
				rvalid_q <= 1'b1;
			end else if (rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// Counter value is sampled at the AR handshake
	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			case (offset)
				MTIME_LO_ADDR: r_q <= '{data: mtime_q[31:0], resp: AXI_RESP_OKAY, last: 1'b1, id: ar.id};
				MTIME_HI_ADDR: r_q <= '{data: mtime_q[63:32], resp: AXI_RESP_OKAY, last: 1'b1, id: ar.id};
				default:       r_q <= '{data: 32'd0, resp: AXI_RESP_SLV, last: 1'b1, id: ar.id};
			endcase
		end
	end

endmodule

// File: verilog/xbar.sv
`timescale 1ns/1ns

module xbar (
	input  logic                  clock,
	input  logic                  arst_n,
	input  cpu_mem_pkg::axi_ar_t  ar,
	input  logic                  arvalid,
	output logic                  arready,
	output cpu_mem_pkg::axi_r_t   r,
	output logic                  rvalid,
	input  logic                  rready,
	input  cpu_mem_pkg::lsu_req_t lsu_req,
	input  logic                  lsu_req_valid,
	output logic                  lsu_req_ready,
	output cpu_mem_pkg::lsu_rsp_t lsu_rsp,
	output logic                  lsu_rsp_valid,
	output cpu_mem_pkg::axi_ar_t  clint_ar,
	output logic                  clint_arvalid,
	input  logic                  clint_arready,
	input  cpu_mem_pkg::axi_r_t   clint_r,
	input  logic                  clint_rvalid,
	output cpu_mem_pkg::axi_ar_t  m_ar,
	output logic                  m_arvalid,
	input  logic                  m_arready,
	input  cpu_mem_pkg::axi_r_t   m_r,
	input  logic                  m_rvalid,
	output logic                  m_rready,
	output cpu_mem_pkg::axi_aw_t  m_aw,
	output logic                  m_awvalid,
	input  logic                  m_awready,
	output cpu_mem_pkg::axi_w_t   m_w,
	output logic                  m_wvalid,
	input  logic                  m_wready,
	input  cpu_mem_pkg::axi_b_t   m_b,
	input  logic                  m_bvalid,
	output logic                  m_bready
);

	import cpu_mem_pkg::*;

	// Owner of the single outstanding read
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_IFU,
		OWN_MEM,
		OWN_CLINT
	} own_t;

	own_t    own_q;
	own_t    own_d;
	own_t    pick;
	logic    ar_done_q;
	logic    aw_done_q;
	logic    w_done_q;
	logic    wr_resp_q;
	logic    lsu_is_clint;
	logic    lsu_busy;
	logic    wr_go;
	logic    wr_accept;
	logic    ar_hs;
	logic    rd_end;
	axi_ar_t lsu_ar;

	assign lsu_is_clint = (lsu_req.addr & CLINT_MASK) == CLINT_BASE;
	assign lsu_busy     = own_q == OWN_MEM || own_q == OWN_CLINT || wr_resp_q;
	assign lsu_ar       = '{addr: lsu_req.addr, id: AXI_ID_LSU, len: 8'd0,
		size: lsu_req.size, burst: AXI_BURST_INCR};

	// Data read beats fetch when both show up while idle
	always_comb begin
		pick = OWN_NONE;
		if (lsu_req_valid && !lsu_req.write && !wr_resp_q) begin
			pick = lsu_is_clint ? OWN_CLINT : OWN_MEM;
		end else if (arvalid) begin
			pick = OWN_IFU;
		end
	end

	// Once a source is presented it stays selected until its read ends
	assign own_d = (own_q == OWN_NONE) ? pick : own_q;

	assign m_ar          = (own_d == OWN_IFU) ? ar : lsu_ar;
	assign m_arvalid     = !ar_done_q && (own_d == OWN_IFU || own_d == OWN_MEM);
	assign clint_ar      = lsu_ar;
	assign clint_arvalid = !ar_done_q && own_d == OWN_CLINT;
	assign arready       = !ar_done_q && own_d == OWN_IFU && m_arready;
	assign ar_hs         = (m_arvalid && m_arready) || (clint_arvalid && clint_arready);

	assign r        = m_r;
	assign rvalid   = m_rvalid && ar_done_q && own_q == OWN_IFU;
	assign m_rready = ar_done_q && (own_q == OWN_MEM || (own_q == OWN_IFU && rready));
	assign rd_end   = ar_done_q && ((own_q == OWN_IFU && m_rvalid && rready && m_r.last) ||
		(own_q == OWN_MEM && m_rvalid) || (own_q == OWN_CLINT && clint_rvalid));

	// Write issues aw and w together and completes once both are taken
	assign wr_go     = lsu_req_valid && lsu_req.write && !lsu_busy;
	assign m_aw      = '{addr: lsu_req.addr, id: AXI_ID_LSU, len: 8'd0,
		size: lsu_req.size, burst: AXI_BURST_INCR};
	assign m_awvalid = wr_go && !aw_done_q;
	assign m_w       = '{data: lsu_req.wdata, strb: lsu_req.wstrb, last: 1'b1};
	assign m_wvalid  = wr_go && !w_done_q;
	assign wr_accept = wr_go && (aw_done_q || m_awready) && (w_done_q || m_wready);
	assign m_bready  = wr_resp_q;

	assign lsu_req_ready = wr_accept || (!ar_done_q && ((own_d == OWN_MEM && m_arready) ||
		(own_d == OWN_CLINT && clint_arready)));

	always_comb begin
		lsu_rsp       = '{rdata: m_r.data, resp: m_r.resp};
		lsu_rsp_valid = ar_done_q && own_q == OWN_MEM && m_rvalid;
		if (wr_resp_q) begin
			lsu_rsp       = '{rdata: 32'd0, resp: m_b.resp};
			lsu_rsp_valid = m_bvalid;
		end else if (own_q == OWN_CLINT) begin
			lsu_rsp       = '{rdata: clint_r.data, resp: clint_r.resp};
			lsu_rsp_valid = ar_done_q && clint_rvalid;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			own_q     <= OWN_NONE;
			ar_done_q <= 1'b0;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			wr_resp_q <= 1'b0;
		end else begin
			if (own_q == OWN_NONE) begin
				own_q <= pick;
			end
			if (ar_hs) begin
				ar_done_q <= 1'b1;
			end
			if (rd_end) begin
				own_q     <= OWN_NONE;
				ar_done_q <= 1'b0;
			end
			if (wr_accept) begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
				wr_resp_q <= 1'b1;
			end else begin
				if (m_awvalid && m_awready) begin
					aw_done_q <= 1'b1;
				end
				if (m_wvalid && m_wready) begin
					w_done_q <= 1'b1;
				end
				if (m_bvalid && m_bready) begin
					wr_resp_q <= 1'b0;
				end
			end
		end
	end

	// Slaves only answer requests that this crossbar has issued
	a_r_expected: assert property (
		@(posedge clock) disable iff (!arst_n)
		m_rvalid |-> ar_done_q && (own_q == OWN_IFU || own_q == OWN_MEM)
	);

	a_b_expected: assert property (
		@(posedge clock) disable iff (!arst_n)
		m_bvalid |-> wr_resp_q
	);

endmodule

// File: verilog/cpu_mem_top.sv
`timescale 1ns/1ns

module cpu_mem_top (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  redirect,
	input  logic [31:0]           redirect_pc,
	input  logic                  fence_i,
	output logic [31:0]           inst,
	output logic [31:0]           inst_pc,
	output logic                  inst_valid,
	input  logic                  inst_ready,
	input  cpu_mem_pkg::lsu_req_t lsu_req,
	input  logic                  lsu_req_valid,
	output logic                  lsu_req_ready,
	output cpu_mem_pkg::lsu_rsp_t lsu_rsp,
	output logic                  lsu_rsp_valid,
	output cpu_mem_pkg::axi_ar_t  m_ar,
	output logic                  m_arvalid,
	input  logic                  m_arready,
	input  cpu_mem_pkg::axi_r_t   m_r,
	input  logic                  m_rvalid,
	output logic                  m_rready,
	output cpu_mem_pkg::axi_aw_t  m_aw,
	output logic                  m_awvalid,
	input  logic                  m_awready,
	output cpu_mem_pkg::axi_w_t   m_w,
	output logic                  m_wvalid,
	input  logic                  m_wready,
	input  cpu_mem_pkg::axi_b_t   m_b,
	input  logic                  m_bvalid,
	output logic                  m_bready
);

	import cpu_mem_pkg::*;

	// Fetch to crossbar
	axi_ar_t     ifu_ar;
	logic        ifu_arvalid;
	logic        ifu_arready;
	axi_r_t      ifu_r;
	logic        ifu_rvalid;
	logic        ifu_rready;

	// Fetch to cache
	logic [31:0] lookup_addr;
	logic        ic_hit;
	logic [31:0] ic_hit_data;
	logic        fill_en;
	logic [31:0] fill_addr;
	logic [31:0] fill_data;
	logic        fill_done;

	// Crossbar to timer
	axi_ar_t     clint_ar;
	logic        clint_arvalid;
	logic        clint_arready;
	axi_r_t      clint_r;
	logic        clint_rvalid;

	ifu i_ifu (
		.clock(clock), .arst_n(arst_n),
		.redirect(redirect), .redirect_pc(redirect_pc), .fence_i(fence_i),
		.inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.ar(ifu_ar), .arvalid(ifu_arvalid), .arready(ifu_arready),
		.r(ifu_r), .rvalid(ifu_rvalid), .rready(ifu_rready),
		.lookup_addr(lookup_addr), .hit(ic_hit), .hit_data(ic_hit_data),
		.fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data), .fill_done(fill_done)
	);

	icache i_icache (
		.clock(clock), .arst_n(arst_n), .fence_i(fence_i),
		.lookup_addr(lookup_addr), .hit(ic_hit), .hit_data(ic_hit_data),
		.fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data), .fill_done(fill_done)
	);

	xbar i_xbar (
		.clock(clock), .arst_n(arst_n),
		.ar(ifu_ar), .arvalid(ifu_arvalid), .arready(ifu_arready),
		.r(ifu_r), .rvalid(ifu_rvalid), .rready(ifu_rready),
		.lsu_req(lsu_req), .lsu_req_valid(lsu_req_valid), .lsu_req_ready(lsu_req_ready),
		.lsu_rsp(lsu_rsp), .lsu_rsp_valid(lsu_rsp_valid),
		.clint_ar(clint_ar), .clint_arvalid(clint_arvalid), .clint_arready(clint_arready),
		.clint_r(clint_r), .clint_rvalid(clint_rvalid),
		.m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready),
		.m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
		.m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
		.m_b(m_b), .m_bvalid(m_bvalid), .m_bready(m_bready)
	);

	// Timer responses are always accepted by the crossbar
	clint i_clint (
		.clock(clock), .arst_n(arst_n),
		.ar(clint_ar), .arvalid(clint_arvalid), .arready(clint_arready),
		.r(clint_r), .rvalid(clint_rvalid), .rready(1'b1)
	);

endmodule

// File: dv/cpu_mem_tb.sv
`timescale 1ns/1ns

module cpu_mem_tb;

	import cpu_mem_pkg::*;

	typedef enum {OP_FETCH, OP_REDIRECT, OP_FENCE, OP_WRITE, OP_READ, OP_TIMER, OP_MISS_READ} op_t;

	typedef struct {
		op_t         op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		int          count;
		logic [1:0]  resp;
		int          bursts;
	} row_t;

	logic clock = 1'b0;
	logic arst_n = 1'b0;
	logic redirect = 1'b0;
	logic [31:0] redirect_pc = '0;
	logic fence_i = 1'b0;
	logic [31:0] inst, inst_pc;
	logic inst_valid;
	logic inst_ready = 1'b0;
	lsu_req_t lsu_req = '0;
	logic lsu_req_valid = 1'b0;
	logic lsu_req_ready;
	lsu_rsp_t lsu_rsp;
	logic lsu_rsp_valid;
	axi_ar_t m_ar;
	logic m_arvalid, m_arready, m_rvalid, m_rready;
	axi_r_t m_r;
	axi_aw_t m_aw;
	logic m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
	axi_w_t m_w;
	axi_b_t m_b;

	logic [31:0] lfsr = 32'h6818;
	logic [7:0]  byte_mem [logic [31:0]];
	row_t        rows[$];
	int          value_errors = 0;
	int          other_errors = 0;
	int          ar_count = 0;
	logic [31:0] exp_pc = RESET_PC;

	cpu_mem_top i_cpu_mem_top (.*);

	always #5 clock = ~clock;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	// Unwritten bytes follow addr XOR A5A5_0000
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [31:0] base;
		logic [31:0] fill;
		logic [31:0] val;
		base = {addr[31:2], 2'b00};
		fill = base ^ 32'hA5A5_0000;
		for (int i = 0; i < 4; i++) begin
			val[8*i +: 8] = byte_mem.exists(base + i) ? byte_mem[base + i] : fill[8*i +: 8];
		end
		return val;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	// Read side of the memory model serves one burst at a time
	initial begin
		axi_ar_t req;
		m_arready = 1'b0;
		m_rvalid  = 1'b0;
		m_r       = '0;
		wait (arst_n);
		forever begin
			@(posedge clock);
			#1;
			repeat (rand_bits(2)) begin
				@(posedge clock);
				#1;
			end
			m_arready = 1'b1;
			do @(posedge clock); while (!m_arvalid);
			req = m_ar;
			ar_count++;
			if (req.id == AXI_ID_IFU && req.len != 8'(LINE_WORDS - 1)) begin
				$display("Fetch burst at %h has length %0d beats", req.addr, req.len + 1);
				other_errors++;
			end
			if (req.id == AXI_ID_IFU && req.addr[OFFSET_W+1:0] != '0) begin
				$display("Fetch burst address %h is not line aligned", req.addr);
				other_errors++;
			end
			if (req.id != AXI_ID_IFU) begin
				check_val("m_ar.id", AXI_ID_LSU, req.id);
				check_val("m_ar.len", 0, req.len);
			end
			check_val("m_ar.size", 2, req.size);
			#1 m_arready = 1'b0;
			for (int b = 0; b <= req.len; b++) begin
				repeat (rand_bits(2)) begin
					@(posedge clock);
					#1;
				end
				m_rvalid = 1'b1;
				m_r = '{data: word_at(req.addr + 4 * b), resp: AXI_RESP_OKAY,
					last: (b == req.len), id: req.id};
				do @(posedge clock); while (!m_rready);
				#1 m_rvalid = 1'b0;
			end
		end
	end

	// On the write side aw is always ready and w is stalled after it
	initial begin
		axi_aw_t     aw;
		logic [31:0] base;
		m_awready = 1'b1;
		m_wready  = 1'b0;
		m_bvalid  = 1'b0;
		m_b       = '0;
		wait (arst_n);
		forever begin
			do @(posedge clock); while (!m_awvalid);
			aw = m_aw;
			check_val("m_aw.id", AXI_ID_LSU, aw.id);
			check_val("m_aw.len", 0, aw.len);
			#1;
			repeat (rand_bits(2)) begin
				@(posedge clock);
				#1;
			end
			m_wready = 1'b1;
			do @(posedge clock); while (!m_wvalid);
			check_val("m_w.last", 1, m_w.last);
			base = {aw.addr[31:2], 2'b00};
			for (int i = 0; i < 4; i++) begin
				if (m_w.strb[i]) begin
					byte_mem[base + i] = m_w.data[8*i +: 8];
				end
			end
			#1 m_wready = 1'b0;
			m_b = '{resp: AXI_RESP_OKAY, id: aw.id};
			m_bvalid = 1'b1;
			do @(posedge clock); while (!m_bready);
			#1 m_bvalid = 1'b0;
		end
	end

	// Wait until the fetch unit presents its next word
	task automatic wait_present();
		while (!inst_valid) @(posedge clock);
	endtask

	task automatic fetch_words(input int n);
		int  hold;
		int  cyc;
		bit  done;
		for (int k = 0; k < n; k++) begin
			hold = rand_bits(2);
			cyc  = 0;
			done = 1'b0;
			#1 inst_ready = (hold == 0);
			while (!done) begin
				@(posedge clock);
				if (inst_valid) begin
					check_val("inst_pc", exp_pc, inst_pc);
					check_val("inst", word_at(exp_pc), inst);
				end
				done = inst_valid && inst_ready;
				if (!done) begin
					#1;
					cyc++;
					inst_ready = (cyc >= hold);
				end
			end
			exp_pc += 4;
		end
		#1 inst_ready = 1'b0;
		wait_present();
	endtask

	task automatic pulse_redirect(input logic [31:0] pc);
		#1;
		redirect    = 1'b1;
		redirect_pc = pc;
		@(posedge clock);
		#1 redirect = 1'b0;
		exp_pc = pc;
	endtask

	task automatic lsu_access(input row_t row, output lsu_rsp_t rsp);
		#1;
		lsu_req = '{addr: row.addr, wdata: row.data, wstrb: row.strb, size: 3'd2,
			write: (row.op == OP_WRITE)};
		lsu_req_valid = 1'b1;
		do @(posedge clock); while (!lsu_req_ready);
		#1 lsu_req_valid = 1'b0;
		do @(posedge clock); while (!lsu_rsp_valid);
		rsp = lsu_rsp;
	endtask

	initial begin
		lsu_rsp_t    rsp;
		logic [31:0] prev_lo;
		int          last_count;
		int          limit;
		prev_lo    = '0;
		last_count = 0;
		limit      = 0;
		rows.push_back('{OP_FETCH, 32'h0, 32'h0, 4'h0, 10, 2'd0, 3});
		rows.push_back('{OP_REDIRECT, 32'h3000_0004, 32'h0, 4'h0, 1, 2'd0, 0});
		rows.push_back('{OP_FETCH, 32'h0, 32'h0, 4'h0, 3, 2'd0, 0});
		rows.push_back('{OP_FENCE, 32'h0, 32'h0, 4'h0, 1, 2'd0, 0});
		rows.push_back('{OP_REDIRECT, 32'h3000_0000, 32'h0, 4'h0, 1, 2'd0, 1});
		rows.push_back('{OP_FETCH, 32'h0, 32'h0, 4'h0, 4, 2'd0, 1});
		rows.push_back('{OP_WRITE, 32'h1000_0010, 32'h1122_3344, 4'h6, 1, AXI_RESP_OKAY, 0});
		rows.push_back('{OP_READ, 32'h1000_0010, 32'hB522_3310, 4'h0, 1, AXI_RESP_OKAY, 1});
		rows.push_back('{OP_TIMER, 32'h0200_BFF8, 32'h0, 4'h0, 1, AXI_RESP_OKAY, 0});
		rows.push_back('{OP_TIMER, 32'h0200_BFF8, 32'h0, 4'h0, 1, AXI_RESP_OKAY, 0});
		rows.push_back('{OP_TIMER, 32'h0200_BFFC, 32'h0, 4'h0, 1, AXI_RESP_OKAY, 0});
		rows.push_back('{OP_TIMER, 32'h0200_0100, 32'h0, 4'h0, 1, AXI_RESP_SLV, 0});
		rows.push_back('{OP_MISS_READ, 32'h3000_0100, 32'hB5A5_0020, 4'h0, 1,
			AXI_RESP_OKAY, 2});
		rows.push_back('{OP_FETCH, 32'h0, 32'h0, 4'h0, 6, 2'd0, 1});
		foreach (rows[i]) begin
			limit += rows[i].count * 200;
		end

		fork
			begin
				repeat (limit + 10) @(posedge clock);
				$display("Timeout: run did not finish within %0d cycles", limit);
				$display("*** TEST FAILED ***");
				$finish;
			end
		join_none

		repeat (10) @(posedge clock);
		#1 arst_n = 1'b1;
		wait_present();

		foreach (rows[i]) begin
			case (rows[i].op)
				OP_FETCH: fetch_words(rows[i].count);
				OP_REDIRECT: begin
					pulse_redirect(rows[i].addr);
					wait_present();
				end
				OP_FENCE: begin
					#1 fence_i = 1'b1;
					@(posedge clock);
					#1 fence_i = 1'b0;
					@(posedge clock);
				end
				OP_MISS_READ: begin
					pulse_redirect(rows[i].addr);
					repeat (2) @(posedge clock);
					// Data read lands while the line refill is under way
					rows[i].addr = 32'h1000_0020;
					lsu_access(rows[i], rsp);
					check_val("lsu_rsp.rdata", rows[i].data, rsp.rdata);
					check_val("lsu_rsp.resp", rows[i].resp, rsp.resp);
					wait_present();
				end
				default: begin
					lsu_access(rows[i], rsp);
					check_val("lsu_rsp.resp", rows[i].resp, rsp.resp);
					if (rows[i].op == OP_TIMER && rows[i].addr[15:0] == MTIME_LO_ADDR) begin
						if (rsp.rdata <= prev_lo) begin
							$display("mtime low word did not increase between reads");
							other_errors++;
						end
						prev_lo = rsp.rdata;
					end else if (rows[i].op != OP_WRITE) begin
						check_val("lsu_rsp.rdata", rows[i].data, rsp.rdata);
					end
				end
			endcase
			check_val("ar_count", rows[i].bursts, ar_count - last_count);
			last_count = ar_count;
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: cpu_mem_top.f
verilog/cpu_mem_pkg.sv
verilog/icache.sv
verilog/ifu.sv
verilog/clint.sv
verilog/xbar.sv
verilog/cpu_mem_top.sv
dv/cpu_mem_tb.sv
